// ==== common/music_defines.svh ====
`ifndef MUSIC_DEFINES_SVH
`define MUSIC_DEFINES_SVH

// number of steps in the melody
`define MELODY_LEN 64

// clock cycles that every step is held
`define STEP_CYCLES 200

// half period of note n is TONE_HALF_BASE - n * TONE_HALF_STEP cycles
`define TONE_HALF_BASE 40
`define TONE_HALF_STEP 2

`endif

// ==== common/melody_pkg.sv ====
`include "music_defines.svh"

package melody_pkg;

   // 0 is a rest, 1 to 15 are pitches, higher code means higher pitch
   typedef logic [3:0] note_code_t;

   localparam note_code_t NOTE_REST = 4'd0;

   typedef logic [$clog2(`MELODY_LEN)-1:0] step_index_t;

   // position and pitch of one melody step
   typedef struct packed {
      step_index_t index;
      note_code_t  note;
   } note_step_t;

endpackage

// ==== common/player_pkg.sv ====
package player_pkg;

   import melody_pkg::*;

   typedef enum logic {
      ST_IDLE,
      ST_PLAY
   } player_state_t;

   // done is a single cycle pulse when the last step runs out
   typedef struct packed {
      logic       playing;
      logic       done;
      note_step_t current;
   } player_status_t;

endpackage

// ==== melody/melody_rom.sv ====
`timescale 1ns/1ns

module melody_rom
   import melody_pkg::*;
(
   input  step_index_t index,
   output note_code_t  note
);

   always_comb begin
      case (index)
         6'd0  : note = 4'd9;
         6'd1  : note = 4'd9;
         6'd2  : note = 4'd4;
         6'd3  : note = 4'd9;
         6'd4  : note = 4'd8;
         6'd5  : note = 4'd7;
         6'd6  : note = 4'd6;
         6'd7  : note = 4'd7;
         6'd8  : note = 4'd10;
         6'd9  : note = 4'd10;
         6'd10 : note = 4'd10;
         6'd11 : note = 4'd10;
         6'd12 : note = 4'd10;
         6'd13 : note = 4'd10;
         6'd14 : note = 4'd4;
         6'd15 : note = 4'd14;
         // second phrase ends on a long held 8
         6'd16 : note = 4'd9;
         6'd17 : note = 4'd9;
         6'd18 : note = 4'd4;
         6'd19 : note = 4'd9;
         6'd20 : note = 4'd8;
         6'd21 : note = 4'd7;
         6'd22 : note = 4'd6;
         6'd23 : note = 4'd7;
         6'd24 : note = 4'd8;
         6'd25 : note = 4'd8;
         6'd26 : note = 4'd8;
         6'd27 : note = 4'd8;
         6'd28 : note = 4'd8;
         6'd29 : note = 4'd8;
         6'd30 : note = 4'd8;
         6'd31 : note = 4'd8;
         6'd32 : note = 4'd9;
         6'd33 : note = 4'd9;
         6'd34 : note = 4'd4;
         6'd35 : note = 4'd9;
         6'd36 : note = 4'd8;
         6'd37 : note = 4'd7;
         6'd38 : note = 4'd6;
         6'd39 : note = 4'd7;
         6'd40 : note = 4'd12;
         6'd41 : note = 4'd12;
         6'd42 : note = 4'd12;
         6'd43 : note = 4'd12;
         6'd44 : note = 4'd12;
         6'd45 : note = 4'd12;
         6'd46 : note = 4'd11;
         6'd47 : note = 4'd10;
         // closing phrase
         6'd48 : note = 4'd9;
         6'd49 : note = 4'd9;
         6'd50 : note = 4'd8;
         6'd51 : note = 4'd7;
         6'd52 : note = 4'd5;
         6'd53 : note = 4'd5;
         6'd54 : note = 4'd6;
         6'd55 : note = 4'd6;
         6'd56 : note = 4'd7;
         6'd57 : note = 4'd7;
         6'd58 : note = 4'd7;
         6'd59 : note = 4'd7;
         6'd60 : note = 4'd14;
         6'd61 : note = 4'd14;
         6'd62 : note = 4'd14;
         6'd63 : note = 4'd14;
         default : note = NOTE_REST;
      endcase
   end

endmodule

// ==== melody/melody_sequencer.sv ====
`timescale 1ns/1ns
`include "music_defines.svh"

module melody_sequencer
   import melody_pkg::*;
   import player_pkg::*;
(
   input  logic           clk,
   input  logic           arst_n,
   input  logic           start,
   input  logic           stop,
   input  logic           step_end,
   input  note_code_t     rom_note,
   output step_index_t    rom_index,
   output logic           timer_run,
   output logic           timer_restart,
   output player_status_t status
);

   localparam step_index_t LAST_STEP = step_index_t'(`MELODY_LEN - 1);

   player_state_t state;
   note_step_t    cur;
   logic          done;

   // the ROM is addressed with the step that gets loaded at the next edge,
   // so index and note move together
   always_comb begin
      if (start) begin
         rom_index = '0;
      end else begin
         rom_index = step_index_t'(cur.index + 1'b1);
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= ST_IDLE;
         cur.index <= '0;
         cur.note  <= NOTE_REST;
         done      <= 1'b0;
      end else begin
         done <= 1'b0;
         // start has priority over stop and restarts from step 0 in any state
         if (start) begin
            state     <= ST_PLAY;
            cur.index <= '0;
            cur.note  <= rom_note;
         end else if (stop) begin
            state     <= ST_IDLE;
            cur.index <= '0;
            cur.note  <= NOTE_REST;
         end else begin
            case (state)
               ST_PLAY: begin
                  if (step_end) begin
                     if (cur.index == LAST_STEP) begin
                        state     <= ST_IDLE;
                        cur.index <= '0;
                        cur.note  <= NOTE_REST;
                        done      <= 1'b1;
                     end else begin
                        cur.index <= rom_index;
                        cur.note  <= rom_note;
                     end
                  end
               end
               default: begin
                  state <= ST_IDLE;
               end
            endcase
         end
      end
   end

   assign timer_run      = (state == ST_PLAY);
   assign timer_restart  = start;

   assign status.playing = (state == ST_PLAY);
   assign status.done    = done;
   assign status.current = cur;

endmodule

// ==== src/step_timer.sv ====
`timescale 1ns/1ns
`include "music_defines.svh"

module step_timer (
   input  logic clk,
   input  logic arst_n,
   input  logic run,
   input  logic restart,
   output logic step_end
);

   localparam int CNT_W = $clog2(`STEP_CYCLES);
   localparam logic [CNT_W-1:0] LAST = CNT_W'(`STEP_CYCLES - 1);

   logic [CNT_W-1:0] count;

   // holding the count at zero while halted keeps the first step full length
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         count <= '0;
      end else if (restart || !run) begin
         count <= '0;
      end else if (count == LAST) begin
         count <= '0;
      end else begin
         count <= count + 1'b1;
      end
   end

   assign step_end = run && (count == LAST);

endmodule

// ==== src/tone_generator.sv ====
`timescale 1ns/1ns
`include "music_defines.svh"

module tone_generator
   import melody_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  note_code_t note,
   output logic       tone
);

   localparam int CNT_W = $clog2(`TONE_HALF_BASE + 1);

   logic [CNT_W-1:0] half_period;
   logic [CNT_W-1:0] cnt;
   note_code_t       last_note;
   logic             tone_q;
   logic             note_changed;

   always_comb begin
      half_period = CNT_W'(`TONE_HALF_BASE - `TONE_HALF_STEP * int'(note));
   end

   assign note_changed = (note != last_note);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         last_note <= NOTE_REST;
         cnt       <= '0;
         tone_q    <= 1'b0;
      end else if (note_changed) begin
         last_note <= note;
         tone_q    <= 1'b0;
         // the change cycle itself is already the first low cycle
         cnt       <= half_period - 2'd2;
      end else if (note == NOTE_REST) begin
         tone_q <= 1'b0;
         cnt    <= '0;
      end else if (cnt == '0) begin
         tone_q <= ~tone_q;
         cnt    <= half_period - 1'b1;
      end else begin
         cnt <= cnt - 1'b1;
      end
   end

   // tone drops in the very cycle a new note shows up
   assign tone = tone_q && !note_changed;

endmodule

// ==== src/music_box_top.sv ====
`timescale 1ns/1ns

module music_box_top
   import melody_pkg::*;
   import player_pkg::*;
(
   input  logic           clk,
   input  logic           arst_n,
   input  logic           start,
   input  logic           stop,
   output player_status_t status,
   output logic           tone
);

   step_index_t rom_index;
   note_code_t  rom_note;
   logic        timer_run;
   logic        timer_restart;
   logic        step_end;

   melody_sequencer i_melody_sequencer (
      .clk           (clk),
      .arst_n        (arst_n),
      .start         (start),
      .stop          (stop),
      .step_end      (step_end),
      .rom_note      (rom_note),
      .rom_index     (rom_index),
      .timer_run     (timer_run),
      .timer_restart (timer_restart),
      .status        (status)
   );

   melody_rom i_melody_rom (
      .index (rom_index),
      .note  (rom_note)
   );

   step_timer i_step_timer (
      .clk      (clk),
      .arst_n   (arst_n),
      .run      (timer_run),
      .restart  (timer_restart),
      .step_end (step_end)
   );

   tone_generator i_tone_generator (
      .clk    (clk),
      .arst_n (arst_n),
      .note   (status.current.note),
      .tone   (tone)
   );

endmodule

// ==== sim/music_box_tb.sv ====
`timescale 1ns/1ns
`include "music_defines.svh"

module music_box_tb
   import melody_pkg::*;
   import player_pkg::*;
();

   localparam int CLK_PERIOD      = 100;
   localparam int DRIVE_DELAY     = 10;
   localparam int MELODY_CYCLES   = `MELODY_LEN * `STEP_CYCLES;
   localparam int WATCHDOG_CYCLES = 4 * MELODY_CYCLES + 100;

   // the tune as written down, one entry per step
   localparam int MELODY_REF [`MELODY_LEN] = '{
      9, 9, 4, 9, 8, 7, 6, 7, 10, 10, 10, 10, 10, 10, 4, 14,
      9, 9, 4, 9, 8, 7, 6, 7, 8, 8, 8, 8, 8, 8, 8, 8,
      9, 9, 4, 9, 8, 7, 6, 7, 12, 12, 12, 12, 12, 12, 11, 10,
      9, 9, 8, 7, 5, 5, 6, 6, 7, 7, 7, 7, 14, 14, 14, 14
   };

   logic           clk;
   logic           arst_n;
   logic           start;
   logic           stop;
   player_status_t status;
   logic           tone;

   int   errors;
   int   checks;
   int   seed;
   int   stop_step;
   int   restart_step;

   // reference model, advanced once per cycle at the falling edge
   logic exp_playing;
   logic exp_done;
   int   exp_cyc;
   int   exp_index;
   int   exp_note;
   int   prev_note;
   logic start_q;
   logic stop_q;
   logic new_seg;
   logic tone_prev;
   logic run_valid;
   int   run_len;
   int   run_note;

   music_box_top i_music_box_top (
      .clk    (clk),
      .arst_n (arst_n),
      .start  (start),
      .stop   (stop),
      .status (status),
      .tone   (tone)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic int half_period_of(input int code);
      return `TONE_HALF_BASE - code * `TONE_HALF_STEP;
   endfunction

   task automatic log_error(input string msg);
      errors = errors + 1;
      $display("** Error: %0t ns: %s", $time, msg);
   endtask

   task automatic send_pulse(input logic start_v, input logic stop_v);
      @(posedge clk);
      #DRIVE_DELAY;
      start = start_v;
      stop  = stop_v;
      @(posedge clk);
      #DRIVE_DELAY;
      start = 1'b0;
      stop  = 1'b0;
   endtask

   task automatic wait_for_done(input int limit);
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n = n + 1;
      end while (status.done !== 1'b1 && n < limit);
      if (status.done !== 1'b1) begin
         errors = errors + 1;
         $display("the done pulse did not arrive within %0d cycles", limit);
      end
   endtask

   done_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
      status.done |-> !status.playing && status.current.note == NOTE_REST)
      else log_error("done is high while playing or with a note");

   done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
      status.done |=> !status.done)
      else log_error("done is high for more than one cycle");

   silent_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
      !status.playing |-> !tone)
      else log_error("tone is high while not playing");

   stop_goes_idle: assert property (@(posedge clk) disable iff (!arst_n)
      stop && !start |=> !status.playing && !status.done && status.current.note == NOTE_REST)
      else log_error("stop did not end playback cleanly");

   start_at_step0: assert property (@(posedge clk) disable iff (!arst_n)
      start |=> status.playing && status.current.index == 0
         && status.current.note == MELODY_REF[0])
      else log_error("start did not begin at step 0");

   always @(negedge clk) begin
      if (!arst_n) begin
         exp_playing = 1'b0;
         exp_done    = 1'b0;
         exp_cyc     = 0;
         exp_index   = 0;
         exp_note    = NOTE_REST;
         prev_note   = NOTE_REST;
         start_q     = 1'b0;
         stop_q      = 1'b0;
         tone_prev   = 1'b0;
         run_valid   = 1'b0;
         run_len     = 0;
         run_note    = 0;
      end else begin
         // apply what the last rising edge sampled with start winning over stop
         exp_done = 1'b0;
         new_seg  = 1'b0;
         if (start_q) begin
            exp_playing = 1'b1;
            exp_cyc     = 0;
            new_seg     = 1'b1;
         end else if (stop_q) begin
            new_seg     = exp_playing;
            exp_playing = 1'b0;
         end else if (exp_playing) begin
            exp_cyc = exp_cyc + 1;
            if (exp_cyc == MELODY_CYCLES) begin
               exp_playing = 1'b0;
               exp_done    = 1'b1;
               new_seg     = 1'b1;
            end else if (exp_cyc % `STEP_CYCLES == 0) begin
               new_seg = 1'b1;
            end
         end
         exp_index = exp_playing ? exp_cyc / `STEP_CYCLES : 0;
         exp_note  = exp_playing ? MELODY_REF[exp_index] : NOTE_REST;
         start_q   = start;
         stop_q    = stop;

         checks = checks + 2;
         assert (status.playing == exp_playing && status.done == exp_done)
            else log_error($sformatf("playing/done %0b/%0b, expected %0b/%0b",
               status.playing, status.done, exp_playing, exp_done));
         assert (status.current.index == exp_index && status.current.note == exp_note)
            else log_error($sformatf("step %0d note %0d, expected step %0d note %0d",
               status.current.index, status.current.note, exp_index, exp_note));

         // a new note restarts the phase low and its first low run begins here
         if (exp_note != prev_note) begin
            checks = checks + 1;
            assert (tone == 1'b0)
               else log_error("tone is not low on the cycle the note changes");
            run_len   = 1;
            run_note  = exp_note;
            run_valid = exp_playing && exp_note != NOTE_REST;
         end else if (tone !== tone_prev) begin
            // a run cut short by a step boundary is not a full half period
            if (!new_seg && run_valid) begin
               checks = checks + 1;
               assert (run_len == half_period_of(run_note))
                  else log_error($sformatf("tone run of %0d cycles for note %0d, expected %0d",
                     run_len, run_note, half_period_of(run_note)));
            end
            run_len   = 1;
            run_note  = exp_note;
            run_valid = exp_playing && exp_note != NOTE_REST;
         end else begin
            run_len = run_len + 1;
            if (new_seg) begin
               run_valid = 1'b0;
            end else if (run_valid) begin
               checks = checks + 1;
               assert (run_len <= half_period_of(run_note))
                  else begin
                     log_error($sformatf("tone held %0d cycles for note %0d, expected %0d",
                        run_len, run_note, half_period_of(run_note)));
                     run_valid = 1'b0;
                  end
            end
         end
         prev_note = exp_note;
         tone_prev = tone;
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      errors = 0;
      checks = 0;
      seed   = 32'h4ff6680f;
      clk    = 1'b0;
      arst_n = 1'b0;
      start  = 1'b0;
      stop   = 1'b0;
      repeat (2) @(posedge clk);
      #DRIVE_DELAY;
      arst_n = 1'b1;
      repeat (20) @(posedge clk);

      // one full melody followed by a quiet gap
      send_pulse(1'b1, 1'b0);
      wait_for_done(MELODY_CYCLES + 10);
      repeat (100) @(posedge clk);

      // stop somewhere inside a random step
      stop_step = {$random(seed)} % `MELODY_LEN;
      send_pulse(1'b1, 1'b0);
      repeat (stop_step * `STEP_CYCLES + `STEP_CYCLES / 4) @(posedge clk);
      send_pulse(1'b0, 1'b1);
      repeat (50) @(posedge clk);

      // restart mid-melody with stop in the same cycle and play to the end
      restart_step = {$random(seed)} % (`MELODY_LEN / 2);
      send_pulse(1'b1, 1'b0);
      repeat (restart_step * `STEP_CYCLES + `STEP_CYCLES / 2) @(posedge clk);
      send_pulse(1'b1, 1'b1);
      wait_for_done(MELODY_CYCLES + 10);
      repeat (20) @(posedge clk);

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
+incdir+common
common/melody_pkg.sv
common/player_pkg.sv
melody/melody_rom.sv
melody/melody_sequencer.sv
src/step_timer.sv
src/tone_generator.sv
src/music_box_top.sv
sim/music_box_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the music box testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=music_box_tb
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" -f sources.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
   echo "result: passed"
   exit 0
fi

echo "result: failed"
exit 1
